// File: Makefile
VERILATOR  ?= verilator
TOP        := tdd_rf_tb
RTL_TOP    := tdd_rf_top
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
logic/tdd_rf_pkg.sv
logic/tdd_cfg_regs.sv
logic/tdd_frame_ctrl.sv
logic/rf_line_timer.sv
logic/rf_switch_bank.sv
logic/tdd_rf_top.sv
tb/tdd_rf_tb.sv

// File: logic/rf_line_timer.sv
`timescale 1ns/1ps

module rf_line_timer #(
	parameter type   line_t   = logic,
	parameter line_t dl_level = '1,
	parameter line_t ul_level = '0
) (
	input  logic                        clk,
	input  logic                        reset,
	input  tdd_rf_pkg::frame_status_t   status,
	input  tdd_rf_pkg::line_thr_t       thr,
	output line_t                       line
);

	import tdd_rf_pkg::*;

	logic to_ul;	// GP1 past this line's switch point
	logic to_dl;	// GP2 past this line's switch point

	assign to_ul = (status.phase == ph_gp1) && (status.gp1_count > thr.gp1_thr);
	assign to_dl = (status.phase == ph_gp2) && (status.gp2_count > thr.gp2_thr);

	always_ff @(posedge clk) begin
		if (reset)
			line <= dl_level;
		else if (status.phase == ph_dl)
			line <= dl_level;
		else if (to_ul)
			line <= ul_level;
		else if (to_dl)
			line <= dl_level;
		else if (status.phase == ph_ul)
			line <= ul_level;
	end

	// A DL cycle forces the line back regardless of thresholds
	a_dl_level: assert property (@(posedge clk) disable iff (reset)
		status.phase == ph_dl |=> line == dl_level)
		else $error("Line not at DL level after DL cycle");

endmodule

// File: logic/rf_switch_bank.sv
`timescale 1ns/1ps

module rf_switch_bank (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          pa_invert,
	input  logic [2:0]                    ant_sel,
	input  tdd_rf_pkg::frame_status_t     status,
	input  tdd_rf_pkg::line_thr_array_t   thr,
	output tdd_rf_pkg::rf_ctrl_t          rf
);

	import tdd_rf_pkg::*;

	// DL levels with UL as the complement of each field
	localparam rf_ctrl_t dl_lvl = '{
		pa_ctrl_en:    8'hff,
		tx_gain_en:    1'b0,
		dac_rf_on:     1'b1,
		sw_pa_rxfb:    2'b11,
		sw_rxfb_dv_en: 8'hff,
		pa_lna_en:     2'b11,
		rx_gain_en:    1'b1,
		sw_pa_lna:     2'b11,
		sw_rxfb:       1'b0,
		sw_rxfb_n:     1'b1,
		prdrv_en:      4'hf
	};

	logic [7:0] pa_ctrl_q;
	logic       tx_gain_q;
	logic       dac_rf_q;
	logic [1:0] sw_pa_rxfb_q;
	logic       rx_gain_q;
	logic [1:0] pa_lna_q;	// Before polarity inversion
	logic [1:0] sw_pa_lna_q;	// Before polarity inversion
	logic       sw_rxfb_q;
	logic       sw_rxfb_n_q;
	logic [3:0] prdrv_q;
	logic [7:0] dv_en_q;

	rf_line_timer #(.line_t(logic [7:0]), .dl_level(dl_lvl.pa_ctrl_en),
		.ul_level(~dl_lvl.pa_ctrl_en)) u_pa_ctrl (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_pa_ctrl]), .line(pa_ctrl_q));

	rf_line_timer #(.line_t(logic), .dl_level(dl_lvl.tx_gain_en),
		.ul_level(~dl_lvl.tx_gain_en)) u_tx_gain (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_tx_gain]), .line(tx_gain_q));

	rf_line_timer #(.line_t(logic), .dl_level(dl_lvl.dac_rf_on),
		.ul_level(~dl_lvl.dac_rf_on)) u_dac_rf (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_dac_rf]), .line(dac_rf_q));

	rf_line_timer #(.line_t(logic [1:0]), .dl_level(dl_lvl.sw_pa_rxfb),
		.ul_level(~dl_lvl.sw_pa_rxfb)) u_sw_pa_rxfb (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_sw_pa_rxfb]),
		.line(sw_pa_rxfb_q));

	rf_line_timer #(.line_t(logic), .dl_level(dl_lvl.rx_gain_en),
		.ul_level(~dl_lvl.rx_gain_en)) u_rx_gain (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_rx_gain]), .line(rx_gain_q));

	rf_line_timer #(.line_t(logic [1:0]), .dl_level(dl_lvl.pa_lna_en),
		.ul_level(~dl_lvl.pa_lna_en)) u_pa_lna_en (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_pa_lna_en]), .line(pa_lna_q));

	rf_line_timer #(.line_t(logic [1:0]), .dl_level(dl_lvl.sw_pa_lna),
		.ul_level(~dl_lvl.sw_pa_lna)) u_sw_pa_lna (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_sw_pa_lna]),
		.line(sw_pa_lna_q));

	rf_line_timer #(.line_t(logic), .dl_level(dl_lvl.sw_rxfb),
		.ul_level(~dl_lvl.sw_rxfb)) u_sw_rxfb (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_sw_rxfb]), .line(sw_rxfb_q));

	rf_line_timer #(.line_t(logic), .dl_level(dl_lvl.sw_rxfb_n),
		.ul_level(~dl_lvl.sw_rxfb_n)) u_sw_rxfb_n (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_sw_rxfb_n]),
		.line(sw_rxfb_n_q));

	rf_line_timer #(.line_t(logic [3:0]), .dl_level(dl_lvl.prdrv_en),
		.ul_level(~dl_lvl.prdrv_en)) u_prdrv (
		.clk(clk), .reset(reset), .status(status), .thr(thr[li_prdrv]), .line(prdrv_q));

	// One-cold feedback antenna select
	always_ff @(posedge clk) begin
		if (reset)
			dv_en_q <= dl_lvl.sw_rxfb_dv_en;
		else
			dv_en_q <= ~(8'd1 << ant_sel);
	end

	// Inverted PA polarity swaps the LNA path drive
	assign rf = '{
		pa_ctrl_en:    pa_ctrl_q,
		tx_gain_en:    tx_gain_q,
		dac_rf_on:     dac_rf_q,
		sw_pa_rxfb:    sw_pa_rxfb_q,
		sw_rxfb_dv_en: dv_en_q,
		pa_lna_en:     pa_lna_q ^ {2{pa_invert}},
		rx_gain_en:    rx_gain_q,
		sw_pa_lna:     sw_pa_lna_q ^ {2{pa_invert}},
		sw_rxfb:       sw_rxfb_q,
		sw_rxfb_n:     sw_rxfb_n_q,
		prdrv_en:      prdrv_q
	};

endmodule

// File: logic/tdd_cfg_regs.sv
`timescale 1ns/1ps

module tdd_cfg_regs #(
	parameter int unsigned gp_total     = 70,
	parameter int unsigned ta_short_len = 26,
	parameter int unsigned ta_long_len  = 40
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          cfg_wr,
	input  logic [3:0]                    cfg_addr,
	input  logic [31:0]                   cfg_wdata,
	output logic                          enable,
	output logic                          pa_invert,
	output tdd_rf_pkg::gp_len_t           gp_len,
	output tdd_rf_pkg::line_thr_array_t   thr
);

	import tdd_rf_pkg::*;

	logic             ta_long_q;
	logic [31:0]      line_off [num_lines];	// GP2 offset high and GP1 offset low
	logic [cnt_w-1:0] gp1_sel;
	logic [cnt_w-1:0] gp2_sel;
	logic [3:0]       line_idx;
	logic             line_hit;

	assign line_idx = cfg_addr - reg_line_base;
	assign line_hit = (cfg_addr >= reg_line_base) && (int'(line_idx) < num_lines);

	always_ff @(posedge clk) begin
		if (reset) begin
			enable    <= 1'b0;
			ta_long_q <= 1'b0;
			pa_invert <= 1'b0;
			line_off  <= '{default: '0};
		end else if (cfg_wr) begin
			case (cfg_addr)
				reg_enable:    enable    <= cfg_wdata[0];
				reg_ta_long:   ta_long_q <= cfg_wdata[0];
				reg_pa_invert: pa_invert <= cfg_wdata[0];
				default: begin
					if (line_hit)
						line_off[line_idx] <= cfg_wdata;
				end
			endcase
		end
	end

	// Long TA moves time from GP1 into GP2 and keeps the sum fixed
	always_comb begin
		gp2_sel = ta_long_q ? cnt_w'(ta_long_len) : cnt_w'(ta_short_len);
		gp1_sel = cnt_w'(gp_total) - gp2_sel;
	end

	always_ff @(posedge clk) begin
		gp_len.gp1_len <= gp1_sel;
		gp_len.gp2_len <= gp2_sel;
		for (int i = 0; i < num_lines; i++) begin
			if (i < int'(li_dac_rf)) begin
				// Early line leaves DL soon after GP1 starts
				thr[i].gp1_thr <= line_off[i][15:0];
				thr[i].gp2_thr <= gp2_sel - line_off[i][31:16] - 16'd2;
			end else begin
				// Late line leaves DL just before UL
				thr[i].gp1_thr <= gp1_sel - line_off[i][15:0] - 16'd2;
				thr[i].gp2_thr <= line_off[i][31:16];
			end
		end
	end

	// GP1 must not vanish with long TA
	a_ta_fits: assert property (@(posedge clk) ta_long_len < gp_total)
		else $error("ta_long_len %0d not below gp_total %0d", ta_long_len, gp_total);

endmodule

// File: logic/tdd_frame_ctrl.sv
`timescale 1ns/1ps

module tdd_frame_ctrl #(
	parameter int unsigned dl_len = 40,
	parameter int unsigned ul_len = 30
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        enable,
	input  tdd_rf_pkg::gp_len_t         gp_len,
	output tdd_rf_pkg::frame_status_t   status
);

	import tdd_rf_pkg::*;

	tdd_phase_t       phase_q;
	logic [cnt_w-1:0] phase_cnt;	// DL and UL position
	logic [cnt_w-1:0] gp1_cnt;
	logic [cnt_w-1:0] gp2_cnt;
	logic             frame_start_q;
	logic             running;
	gp_len_t          gp_q;		// Guard lengths for the current frame
	logic             phase_done;
	logic             frame_end;
	logic             start_frame;

	always_comb begin
		case (phase_q)
			ph_dl:   phase_done = (phase_cnt == cnt_w'(dl_len - 1));
			ph_gp1:  phase_done = (gp1_cnt == gp_q.gp1_len - 16'd1);
			ph_ul:   phase_done = (phase_cnt == cnt_w'(ul_len - 1));
			default: phase_done = (gp2_cnt == gp_q.gp2_len - 16'd1);
		endcase
	end

	assign frame_end   = running && (phase_q == ph_gp2) && phase_done;
	assign start_frame = enable && (!running || frame_end);

	always_ff @(posedge clk) begin
		if (reset || !enable) begin
			phase_q       <= ph_dl;
			phase_cnt     <= '0;
			gp1_cnt       <= '0;
			gp2_cnt       <= '0;
			frame_start_q <= 1'b0;
			running       <= 1'b0;
		end else if (start_frame) begin
			phase_q       <= ph_dl;
			phase_cnt     <= '0;
			gp1_cnt       <= '0;
			gp2_cnt       <= '0;
			frame_start_q <= 1'b1;	// First DL cycle of the frame
			running       <= 1'b1;
		end else begin
			frame_start_q <= 1'b0;
			case (phase_q)
				ph_dl: begin
					phase_cnt <= phase_done ? '0 : phase_cnt + 16'd1;
					if (phase_done)
						phase_q <= ph_gp1;
				end
				ph_gp1: begin
					gp1_cnt <= phase_done ? '0 : gp1_cnt + 16'd1;
					if (phase_done)
						phase_q <= ph_ul;
				end
				ph_ul: begin
					phase_cnt <= phase_done ? '0 : phase_cnt + 16'd1;
					if (phase_done)
						phase_q <= ph_gp2;
				end
				default: gp2_cnt <= gp2_cnt + 16'd1;	// End handled by start_frame
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_frame)
			gp_q <= gp_len;
	end

	assign status = '{
		phase:       phase_q,
		gp1_count:   gp1_cnt,
		gp2_count:   gp2_cnt,
		frame_start: frame_start_q
	};

	a_phase_order: assert property (@(posedge clk) disable iff (reset)
		(status.phase != $past(status.phase)) |->
			(status.phase == ph_dl || status.phase == $past(status.phase) + 2'd1))
		else $error("Phase jumped out of order");

	a_start_in_dl: assert property (@(posedge clk) disable iff (reset)
		status.frame_start |-> status.phase == ph_dl)
		else $error("frame_start outside DL");

endmodule

// File: logic/tdd_rf_pkg.sv
package tdd_rf_pkg;

	typedef enum logic [1:0] {
		ph_dl  = 2'd0,
		ph_gp1 = 2'd1,
		ph_ul  = 2'd2,
		ph_gp2 = 2'd3
	} tdd_phase_t;

	localparam int cnt_w = 16;	// Phase and guard counter width

	typedef struct packed {
		logic [cnt_w-1:0] gp1_len;
		logic [cnt_w-1:0] gp2_len;
	} gp_len_t;

	typedef struct packed {
		tdd_phase_t       phase;
		logic [cnt_w-1:0] gp1_count;	// Zero outside GP1
		logic [cnt_w-1:0] gp2_count;	// Zero outside GP2
		logic             frame_start;
	} frame_status_t;

	typedef struct packed {
		logic [cnt_w-1:0] gp1_thr;	// DL to UL switch point
		logic [cnt_w-1:0] gp2_thr;	// UL to DL switch point
	} line_thr_t;

	localparam int num_lines = 10;

	typedef line_thr_t [num_lines-1:0] line_thr_array_t;

	// Lines below li_dac_rf switch early in GP1 and late in GP2
	typedef enum logic [3:0] {
		li_pa_ctrl    = 4'd0,
		li_tx_gain    = 4'd1,
		li_dac_rf     = 4'd2,
		li_sw_pa_rxfb = 4'd3,
		li_rx_gain    = 4'd4,
		li_pa_lna_en  = 4'd5,
		li_sw_pa_lna  = 4'd6,
		li_sw_rxfb    = 4'd7,
		li_sw_rxfb_n  = 4'd8,
		li_prdrv      = 4'd9
	} line_id_t;

	localparam logic [3:0] reg_enable    = 4'd0;
	localparam logic [3:0] reg_ta_long   = 4'd1;
	localparam logic [3:0] reg_pa_invert = 4'd2;
	localparam logic [3:0] reg_line_base = 4'd4;	// Line i at base plus i

	typedef struct packed {
		logic [7:0] pa_ctrl_en;
		logic       tx_gain_en;
		logic       dac_rf_on;
		logic [1:0] sw_pa_rxfb;
		logic [7:0] sw_rxfb_dv_en;
		logic [1:0] pa_lna_en;
		logic       rx_gain_en;
		logic [1:0] sw_pa_lna;
		logic       sw_rxfb;
		logic       sw_rxfb_n;
		logic [3:0] prdrv_en;
	} rf_ctrl_t;

endpackage

// File: logic/tdd_rf_top.sv
`timescale 1ns/1ps

module tdd_rf_top #(
	parameter int unsigned dl_len       = 40,
	parameter int unsigned ul_len       = 30,
	parameter int unsigned gp_total     = 70,
	parameter int unsigned ta_short_len = 26,
	parameter int unsigned ta_long_len  = 40
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cfg_wr,
	input  logic [3:0]              cfg_addr,
	input  logic [31:0]             cfg_wdata,
	input  logic [2:0]              ant_sel,
	output tdd_rf_pkg::rf_ctrl_t    rf,
	output tdd_rf_pkg::tdd_phase_t  phase,
	output logic                    frame_start
);

	import tdd_rf_pkg::*;

	logic            enable;
	logic            pa_invert;
	gp_len_t         gp_len;
	line_thr_array_t thr;
	frame_status_t   status;

	tdd_cfg_regs #(
		.gp_total    (gp_total),
		.ta_short_len(ta_short_len),
		.ta_long_len (ta_long_len)
	) u_cfg_regs (
		.clk      (clk),
		.reset    (reset),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_wdata(cfg_wdata),
		.enable   (enable),
		.pa_invert(pa_invert),
		.gp_len   (gp_len),
		.thr      (thr)
	);

	tdd_frame_ctrl #(
		.dl_len(dl_len),
		.ul_len(ul_len)
	) u_frame_ctrl (
		.clk   (clk),
		.reset (reset),
		.enable(enable),
		.gp_len(gp_len),
		.status(status)
	);

	rf_switch_bank u_switch_bank (
		.clk      (clk),
		.reset    (reset),
		.pa_invert(pa_invert),
		.ant_sel  (ant_sel),
		.status   (status),
		.thr      (thr),
		.rf       (rf)
	);

	assign phase       = status.phase;
	assign frame_start = status.frame_start;	// One cycle at each frame start

endmodule

// File: tb/tdd_rf_tb.sv
`timescale 1ns/1ps

module tdd_rf_tb;

	import tdd_rf_pkg::*;

	localparam int unsigned dl_len       = 40;
	localparam int unsigned ul_len       = 30;
	localparam int unsigned gp_total     = 70;
	localparam int unsigned ta_short_len = 26;
	localparam int unsigned ta_long_len  = 40;
	localparam int unsigned clk_period   = 40;
	localparam int unsigned frame_max    = dl_len + ul_len + gp_total;
	localparam int unsigned off_limit    = ta_short_len - 2;	// Short TA GP2 is the shortest guard

	logic        clk;
	logic        reset;
	logic        cfg_wr;
	logic [3:0]  cfg_addr;
	logic [31:0] cfg_wdata;
	logic [2:0]  ant_sel;
	rf_ctrl_t    rf;
	tdd_phase_t  phase;
	logic        frame_start;
	integer      seed;
	string       test_name;

	// Reference model state
	logic                 en_m;
	logic                 ta_m;
	logic                 inv_m;
	logic [31:0]          off_m [num_lines];	// GP2 offset high and GP1 offset low
	logic [15:0]          gp2_sel;
	logic [15:0]          len1_m;
	logic [15:0]          len2_m;
	logic [15:0]          thr1_m [num_lines];
	logic [15:0]          thr2_m [num_lines];
	logic                 run_m;
	tdd_phase_t           ph_m;
	logic [15:0]          cnt_m;	// Position inside the current phase
	logic [15:0]          g1_m;	// Guard lengths of the running frame
	logic [15:0]          g2_m;
	logic [15:0]          ph_len;
	logic                 fs_m;
	logic [num_lines-1:0] ul_m;	// Set while a line sits at its UL level
	logic [7:0]           dv_m;
	rf_ctrl_t             exp_rf;
	rf_ctrl_t             idle_rf;

	tdd_rf_top #(
		.dl_len      (dl_len),
		.ul_len      (ul_len),
		.gp_total    (gp_total),
		.ta_short_len(ta_short_len),
		.ta_long_len (ta_long_len)
	) u_dut (
		.clk        (clk),
		.reset      (reset),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.ant_sel    (ant_sel),
		.rf         (rf),
		.phase      (phase),
		.frame_start(frame_start)
	);

	function automatic rf_ctrl_t rf_expect(input logic [num_lines-1:0] ul, input logic inv,
		input logic [7:0] dv);
		rf_ctrl_t r;
		r.pa_ctrl_en    = ul[li_pa_ctrl] ? 8'h00 : 8'hff;
		r.tx_gain_en    = ul[li_tx_gain];
		r.dac_rf_on     = !ul[li_dac_rf];
		r.sw_pa_rxfb    = ul[li_sw_pa_rxfb] ? 2'b00 : 2'b11;
		r.sw_rxfb_dv_en = dv;
		r.pa_lna_en     = (ul[li_pa_lna_en] ? 2'b00 : 2'b11) ^ {2{inv}};
		r.rx_gain_en    = !ul[li_rx_gain];
		r.sw_pa_lna     = (ul[li_sw_pa_lna] ? 2'b00 : 2'b11) ^ {2{inv}};
		r.sw_rxfb       = ul[li_sw_rxfb];
		r.sw_rxfb_n     = !ul[li_sw_rxfb_n];
		r.prdrv_en      = ul[li_prdrv] ? 4'h0 : 4'hf;
		return r;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	assign gp2_sel = ta_m ? 16'(ta_long_len) : 16'(ta_short_len);
	assign ph_len  = (ph_m == ph_dl) ? 16'(dl_len) : (ph_m == ph_gp1) ? g1_m :
		(ph_m == ph_ul) ? 16'(ul_len) : g2_m;

	// Guard lengths and thresholds follow the registers by one cycle
	always @(posedge clk) begin
		len2_m <= gp2_sel;
		len1_m <= 16'(gp_total) - gp2_sel;
		for (int i = 0; i < num_lines; i++) begin
			if (i == int'(li_pa_ctrl) || i == int'(li_tx_gain)) begin
				thr1_m[i] <= off_m[i][15:0];
				thr2_m[i] <= gp2_sel - off_m[i][31:16] - 16'd2;
			end else begin
				thr1_m[i] <= 16'(gp_total) - gp2_sel - off_m[i][15:0] - 16'd2;
				thr2_m[i] <= off_m[i][31:16];
			end
		end
	end

	always @(posedge clk) begin
		if (reset || !en_m) begin
			run_m <= 1'b0;
			ph_m  <= ph_dl;
			cnt_m <= '0;
			fs_m  <= 1'b0;
		end else if (!run_m || (ph_m == ph_gp2 && cnt_m == g2_m - 16'd1)) begin
			run_m <= 1'b1;
			ph_m  <= ph_dl;
			cnt_m <= '0;
			fs_m  <= 1'b1;
			g1_m  <= len1_m;	// Latched once per frame
			g2_m  <= len2_m;
		end else begin
			fs_m <= 1'b0;
			if (cnt_m == ph_len - 16'd1) begin
				ph_m  <= tdd_phase_t'(ph_m + 2'd1);
				cnt_m <= '0;
			end else begin
				cnt_m <= cnt_m + 16'd1;
			end
		end
	end

	always @(posedge clk) begin
		for (int i = 0; i < num_lines; i++) begin
			if (reset || ph_m == ph_dl)
				ul_m[i] <= 1'b0;
			else if (ph_m == ph_gp1 && cnt_m > thr1_m[i])
				ul_m[i] <= 1'b1;
			else if (ph_m == ph_gp2 && cnt_m > thr2_m[i])
				ul_m[i] <= 1'b0;
			else if (ph_m == ph_ul)
				ul_m[i] <= 1'b1;
		end
	end

	always @(posedge clk)
		for (int b = 0; b < 8; b++)
			dv_m[b] <= reset || (b != int'(ant_sel));	// One zero at the selected antenna

	always_comb exp_rf = rf_expect(ul_m, inv_m, dv_m);
	always_comb idle_rf = rf_expect('0, 1'b0, dv_m);

	a_rf: assert property (@(posedge clk) disable iff (reset) rf == exp_rf)
		else stop_on_error($sformatf("Error: %s rf expected %h actual %h",
			test_name, $sampled(exp_rf), $sampled(rf)));

	a_phase: assert property (@(posedge clk) disable iff (reset) phase == ph_m)
		else stop_on_error($sformatf("Error: %s phase expected %0d actual %0d",
			test_name, $sampled(ph_m), $sampled(phase)));

	a_start: assert property (@(posedge clk) disable iff (reset) frame_start == fs_m)
		else stop_on_error($sformatf("Error: %s frame_start expected %0b actual %0b",
			test_name, $sampled(fs_m), $sampled(frame_start)));

	// Three disabled cycles let every line settle back to DL
	a_idle: assert property (@(posedge clk) disable iff (reset)
		!en_m && !$past(en_m) && !$past(en_m, 2) && !inv_m |->
			rf == idle_rf && phase == ph_dl)
		else stop_on_error($sformatf("Error: %s idle rf expected %h actual %h",
			test_name, $sampled(idle_rf), $sampled(rf)));

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clk);
		cfg_wr    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(posedge clk);
		case (addr)	// Same edge as the DUT registers
			reg_enable:    en_m  <= data[0];
			reg_ta_long:   ta_m  <= data[0];
			reg_pa_invert: inv_m <= data[0];
			default:       off_m[addr - reg_line_base] <= data;
		endcase
		@(negedge clk);
		cfg_wr = 1'b0;
	endtask

	task automatic load_offsets();
		logic [15:0] off1;
		logic [15:0] off2;
		for (int i = 0; i < num_lines; i++) begin
			off1 = 16'({$random(seed)} % off_limit);
			off2 = 16'({$random(seed)} % off_limit);
			write_reg(reg_line_base + 4'(i), {off2, off1});
		end
	endtask

	task automatic run_frames(input int n);
		int seen;
		int ticks;
		seen  = 0;
		ticks = 0;
		while (seen < n) begin
			@(negedge clk);
			ticks++;
			if (frame_start)
				seen++;
			if (ticks % 9 == 0)
				ant_sel = 3'($random(seed));	// Keep the antenna decode moving
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(clk_period * (12 * frame_max + 400));
		stop_on_error("Watchdog expired before the test sequence finished");
	end

	initial begin
		seed      = 32'hdf1899b6;
		reset     = 1'b1;
		cfg_wr    = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		ant_sel   = '0;
		en_m      <= 1'b0;
		ta_m      <= 1'b0;
		inv_m     <= 1'b0;
		test_name = "reset";
		foreach (off_m[i])
			off_m[i] <= '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		test_name = "idle";
		repeat (6) @(negedge clk);
		ant_sel = 3'd5;
		repeat (4) @(negedge clk);

		test_name = "short_ta";
		load_offsets();
		write_reg(reg_enable, 32'd1);
		run_frames(3);

		test_name = "pa_invert";
		write_reg(reg_pa_invert, 32'd1);
		run_frames(2);
		write_reg(reg_pa_invert, 32'd0);

		test_name = "long_ta";
		write_reg(reg_enable, 32'd0);
		write_reg(reg_ta_long, 32'd1);
		load_offsets();
		write_reg(reg_enable, 32'd1);
		run_frames(3);

		test_name = "enable_drop";
		do
			@(negedge clk);
		while (phase != ph_ul);
		write_reg(reg_enable, 32'd0);
		repeat (6) @(negedge clk);
		write_reg(reg_ta_long, 32'd0);
		write_reg(reg_enable, 32'd1);
		run_frames(2);
		repeat (4) @(negedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule
